// File: verilog/aes_inv_pkg.sv
// Shared types and register map for the AES-128 inverse round engine.
// RTL modules import this package; ports use its types by scoped name.
`default_nettype none

package aes_inv_pkg;

    // byte 0 sits in bits 127:120, bytes are column-major
    typedef logic [127:0] aes_state_t;

    // the final round leaves out InvMixColumns
    typedef enum logic {
        ROUND_MIDDLE = 1'b0,
        ROUND_FINAL  = 1'b1
    } round_kind_e;

    typedef struct packed {
        aes_state_t  state;
        aes_state_t  key;
        round_kind_e kind;
    } round_req_t;

    typedef struct packed {
        aes_state_t  state;
        aes_state_t  key;
        round_kind_e kind;
    } sub_out_t;

    typedef enum logic [1:0] {
        CTRL_IDLE = 2'd0,
        CTRL_BUSY = 2'd1,
        CTRL_DONE = 2'd2
    } ctrl_state_e;

    // word addresses, word w holds state bytes 4w to 4w+3
    localparam logic [3:0] REG_STATE_IN0 = 4'd0;
    localparam logic [3:0] REG_STATE_IN1 = 4'd1;
    localparam logic [3:0] REG_STATE_IN2 = 4'd2;
    localparam logic [3:0] REG_STATE_IN3 = 4'd3;
    localparam logic [3:0] REG_KEY0      = 4'd4;
    localparam logic [3:0] REG_KEY1      = 4'd5;
    localparam logic [3:0] REG_KEY2      = 4'd6;
    localparam logic [3:0] REG_KEY3      = 4'd7;
    localparam logic [3:0] REG_CTRL      = 4'd8;
    localparam logic [3:0] REG_STATUS    = 4'd9;
    localparam logic [3:0] REG_RESULT0   = 4'd12;
    localparam logic [3:0] REG_RESULT1   = 4'd13;
    localparam logic [3:0] REG_RESULT2   = 4'd14;
    localparam logic [3:0] REG_RESULT3   = 4'd15;

    // number of register stages between req_valid and res_valid
    localparam int PIPE_DEPTH = 2;

endpackage

`default_nettype wire

// File: verilog/aes_sbox_n.sv
// Combinational inverse AES S-box, one byte in and one byte out.
// Stage 1 instantiates sixteen of these, one per state byte.
`timescale 1ns/1ps
`default_nettype none

module aes_sbox_n (
    input  wire  [7:0] din,
    output logic [7:0] dout
);

    logic [127:0] row;

    // the upper nibble picks a table row of sixteen bytes
    always_comb begin
        case (din[7:4])
            4'h0: row = 128'h52096ad53036a538bf40a39e81f3d7fb;
            4'h1: row = 128'h7ce339829b2fff87348e4344c4dee9cb;
            4'h2: row = 128'h547b9432a6c2233dee4c950b42fac34e;
            4'h3: row = 128'h082ea16628d924b2765ba2496d8bd125;
            4'h4: row = 128'h72f8f66486689816d4a45ccc5d65b692;
            4'h5: row = 128'h6c704850fdedb9da5e154657a78d9d84;
            4'h6: row = 128'h90d8ab008cbcd30af7e45805b8b34506;
            4'h7: row = 128'hd02c1e8fca3f0f02c1afbd0301138a6b;
            4'h8: row = 128'h3a9111414f67dcea97f2cfcef0b4e673;
            4'h9: row = 128'h96ac7422e7ad3585e2f937e81c75df6e;
            4'ha: row = 128'h47f11a711d29c5896fb7620eaa18be1b;
            4'hb: row = 128'hfc563e4bc6d279209adbc0fe78cd5af4;
            4'hc: row = 128'h1fdda8338807c731b11210592780ec5f;
            4'hd: row = 128'h60517fa919b54a0d2de57a9f93c99cef;
            4'he: row = 128'ha0e03b4dae2af5b0c8ebbb3c83539961;
            default: row = 128'h172b047eba77d626e169146355210c7d;
        endcase
    end

    // and the lower nibble picks the byte within it, left to right
    assign dout = row[127 - 8*din[3:0] -: 8];

endmodule

`default_nettype wire

// File: verilog/aes_inv_sub_shift.sv
// Pipeline stage 1: InvShiftRows then InvSubBytes, registered.
// Takes a round request from the register block and feeds stage 2.
`timescale 1ns/1ps
`default_nettype none

module aes_inv_sub_shift (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          req_valid,
    input  wire aes_inv_pkg::round_req_t req,
    output logic                         sub_valid,
    output aes_inv_pkg::sub_out_t        sub
);

    import aes_inv_pkg::*;

    aes_state_t shifted;
    aes_state_t subbed;

    // byte at row r, column c has index 4c+r, and row r moves right by r columns
    for (genvar c = 0; c < 4; c++) begin : g_col
        for (genvar r = 0; r < 4; r++) begin : g_row
            assign shifted[127 - 8*(4*c + r) -: 8] =
                req.state[127 - 8*(4*((c + 4 - r) % 4) + r) -: 8];

            aes_sbox_n u_sbox (
                .din  (shifted[127 - 8*(4*c + r) -: 8]),
                .dout (subbed[127 - 8*(4*c + r) -: 8])
            );
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sub_valid <= 1'b0;
        end else begin
            sub_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            sub.state <= subbed;
            sub.key   <= req.key;
            sub.kind  <= req.kind;
        end
    end

    // the register block never issues back-to-back requests
    a_single_flight: assert property (@(posedge clk) disable iff (!rst_n)
        sub_valid |=> !sub_valid);

endmodule

`default_nettype wire

// File: verilog/aes_inv_key_mix.sv
// Pipeline stage 2: AddRoundKey, then InvMixColumns for middle rounds.
// The registered result goes back to the register block.
`timescale 1ns/1ps
`default_nettype none

module aes_inv_key_mix (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        sub_valid,
    input  wire aes_inv_pkg::sub_out_t sub,
    output logic                       res_valid,
    output aes_inv_pkg::aes_state_t    res
);

    import aes_inv_pkg::*;

    aes_state_t keyed;
    aes_state_t mixed;

    // multiply by x in GF(2^8) modulo 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // one column through the matrix rows {0e 0b 0d 09} rotated
    function automatic logic [31:0] inv_mix_col(input logic [31:0] col);
        logic [7:0] a   [4];
        logic [7:0] x2  [4];
        logic [7:0] x4  [4];
        logic [7:0] x8  [4];
        logic [7:0] m9  [4];
        logic [7:0] m11 [4];
        logic [7:0] m13 [4];
        logic [7:0] m14 [4];
        for (int i = 0; i < 4; i++) begin
            a[i]   = col[31 - 8*i -: 8];
            x2[i]  = xtime(a[i]);
            x4[i]  = xtime(x2[i]);
            x8[i]  = xtime(x4[i]);
            m9[i]  = x8[i] ^ a[i];
            m11[i] = x8[i] ^ x2[i] ^ a[i];
            m13[i] = x8[i] ^ x4[i] ^ a[i];
            m14[i] = x8[i] ^ x4[i] ^ x2[i];
        end
        return {m14[0] ^ m11[1] ^ m13[2] ^ m9[3],
                m9[0]  ^ m14[1] ^ m11[2] ^ m13[3],
                m13[0] ^ m9[1]  ^ m14[2] ^ m11[3],
                m11[0] ^ m13[1] ^ m9[2]  ^ m14[3]};
    endfunction

    always_comb begin
        keyed = sub.state ^ sub.key;
        mixed = keyed;
        if (sub.kind == ROUND_MIDDLE) begin
            for (int w = 0; w < 4; w++) begin
                mixed[127 - 32*w -: 32] = inv_mix_col(keyed[127 - 32*w -: 32]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= sub_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sub_valid) begin
            res <= mixed;
        end
    end

endmodule

`default_nettype wire

// File: verilog/aes_inv_round_regs.sv
// Wishbone classic slave holding the input, key, control and result registers.
// A start write snapshots state and key into one pipeline request.
`timescale 1ns/1ps
`default_nettype none

module aes_inv_round_regs (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          wb_cyc,
    input  wire                          wb_stb,
    input  wire                          wb_we,
    input  wire  [3:0]                   wb_adr,
    input  wire  [31:0]                  wb_dat_w,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack,
    output logic                         req_valid,
    output aes_inv_pkg::round_req_t      req,
    input  wire                          res_valid,
    input  wire aes_inv_pkg::aes_state_t res
);

    import aes_inv_pkg::*;

    logic [31:0] state_in [4];
    logic [31:0] key_w    [4];
    logic [31:0] result   [4];
    logic        ctrl_final;
    ctrl_state_e ctrl_state;
    logic        access;
    logic        wr_en;
    logic        start_wr;
    logic        busy;
    logic        done;
    logic [31:0] rd_data;

    // a new bus cycle is one that has not been acked yet
    assign access   = wb_cyc && wb_stb && !wb_ack;
    assign wr_en    = access && wb_we;
    assign start_wr = wr_en && (wb_adr == REG_CTRL) && wb_dat_w[0];
    assign busy     = (ctrl_state == CTRL_BUSY);
    assign done     = (ctrl_state == CTRL_DONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

    // input and key words, writable at any time
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wb_adr)
                REG_STATE_IN0, REG_STATE_IN1, REG_STATE_IN2, REG_STATE_IN3:
                    state_in[wb_adr[1:0]] <= wb_dat_w;
                REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3:
                    key_w[wb_adr[1:0]] <= wb_dat_w;
                default: ;
            endcase
        end
    end

    // controller; a start while busy is acked but otherwise dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_state <= CTRL_IDLE;
            ctrl_final <= 1'b0;
            req_valid  <= 1'b0;
            result     <= '{default: '0};
        end else begin
            req_valid <= 1'b0;
            if (wr_en && wb_adr == REG_CTRL) begin
                ctrl_final <= wb_dat_w[1];
            end
            case (ctrl_state)
                CTRL_IDLE, CTRL_DONE: begin
                    if (start_wr) begin
                        ctrl_state <= CTRL_BUSY;
                        req_valid  <= 1'b1;
                    end
                end
                CTRL_BUSY: begin
                    if (res_valid) begin
                        ctrl_state <= CTRL_DONE;
                        result[0]  <= res[127:96];
                        result[1]  <= res[95:64];
                        result[2]  <= res[63:32];
                        result[3]  <= res[31:0];
                    end
                end
                default: ctrl_state <= CTRL_IDLE;
            endcase
        end
    end

    // the request payload is the register contents at the accepted start
    always_ff @(posedge clk) begin
        if (start_wr && !busy) begin
            req.state <= {state_in[0], state_in[1], state_in[2], state_in[3]};
            req.key   <= {key_w[0], key_w[1], key_w[2], key_w[3]};
            req.kind  <= round_kind_e'(wb_dat_w[1]);
        end
    end

    always_comb begin
        case (wb_adr)
            REG_STATE_IN0, REG_STATE_IN1, REG_STATE_IN2, REG_STATE_IN3:
                rd_data = state_in[wb_adr[1:0]];
            REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3:
                rd_data = key_w[wb_adr[1:0]];
            REG_CTRL:   rd_data = {30'd0, ctrl_final, 1'b0};
            REG_STATUS: rd_data = {30'd0, done, busy};
            REG_RESULT0, REG_RESULT1, REG_RESULT2, REG_RESULT3:
                rd_data = result[wb_adr[1:0]];
            default:    rd_data = 32'd0;
        endcase
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb));

    a_res_timing: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (ctrl_state == CTRL_BUSY) && $past(req_valid, PIPE_DEPTH));

endmodule

`default_nettype wire

// File: verilog/aes_inv_round_top.sv
// Top level of the AES-128 inverse round engine on a Wishbone classic bus.
// Joins the register block with the two pipeline stages.
`timescale 1ns/1ps
`default_nettype none

module aes_inv_round_top (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire  [3:0]  wb_adr,
    input  wire  [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    import aes_inv_pkg::*;

    logic       req_valid;
    round_req_t req;
    logic       sub_valid;
    sub_out_t   sub;
    logic       res_valid;
    aes_state_t res;

    aes_inv_round_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

    aes_inv_sub_shift u_sub_shift (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .sub_valid (sub_valid),
        .sub       (sub)
    );

    aes_inv_key_mix u_key_mix (
        .clk       (clk),
        .rst_n     (rst_n),
        .sub_valid (sub_valid),
        .sub       (sub),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

// File: tests/aes_inv_round_tb.sv
// Testbench for the AES-128 inverse round engine, driven over Wishbone classic.
// Expected results come from a bit-level software model of one inverse round.
`timescale 1ns/1ps
`default_nettype none

module aes_inv_round_tb;

    import aes_inv_pkg::*;

    localparam int NUM_ROUNDS      = 16 + 200 + 2;
    localparam int WATCHDOG_CYCLES = NUM_ROUNDS * 40 + 1000;
    localparam int ACK_LIMIT       = 8;
    localparam int POLL_LIMIT      = 20;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    aes_inv_round_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // multiply in GF(2^8) modulo 0x11b, shift and add
    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ x;
            end
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // a^254 is the inverse of a, and zero stays zero
    function automatic logic [7:0] ginv(input logic [7:0] a);
        logic [7:0] sq;
        logic [7:0] r;
        sq = a;
        r  = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq = gmul(sq, sq);
            r  = gmul(r, sq);
        end
        return r;
    endfunction

    // bit i takes bits i+2, i+5 and i+7, then the constant 0x05
    function automatic logic [7:0] inv_affine(input logic [7:0] y);
        return {y[6:0], y[7]} ^ {y[4:0], y[7:5]} ^ {y[1:0], y[7:2]} ^ 8'h05;
    endfunction

    function automatic logic [7:0] inv_sbox(input logic [7:0] y);
        return ginv(inv_affine(y));
    endfunction

    function automatic aes_state_t inv_round(input aes_state_t st, input aes_state_t key,
                                             input round_kind_e kind);
        logic [7:0] t    [16];
        logic [7:0] m    [16];
        logic [7:0] coef [4];
        aes_state_t out;
        coef = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
        // byte at row r of column c lands r columns further right
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                t[4*((c + r) % 4) + r] = inv_sbox(st[127 - 8*(4*c + r) -: 8]);
            end
        end
        for (int k = 0; k < 16; k++) begin
            t[k] = t[k] ^ key[127 - 8*k -: 8];
            m[k] = t[k];
        end
        if (kind == ROUND_MIDDLE) begin
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    m[4*c + r] = 8'h00;
                    for (int j = 0; j < 4; j++) begin
                        m[4*c + r] = m[4*c + r] ^ gmul(t[4*c + j], coef[(j - r + 4) % 4]);
                    end
                end
            end
        end
        for (int k = 0; k < 16; k++) begin
            out[127 - 8*k -: 8] = m[k];
        end
        return out;
    endfunction

    task automatic check_state(input string name, input aes_state_t got, input aes_state_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // each call starts and ends 1 ns after a rising edge
    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > ACK_LIMIT) begin
                $display("no ack within %0d cycles for address %0d", ACK_LIMIT, wb_adr);
                abort_run();
            end
        end while (!wb_ack);
    endtask

    // the master keeps the cycle open through the edge where it samples ack
    task automatic close_cycle();
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_ack();
        close_cycle();
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        data = wb_dat_r;
        close_cycle();
    endtask

    task automatic load_inputs(input aes_state_t st, input aes_state_t key);
        for (int w = 0; w < 4; w++) begin
            wb_write(REG_STATE_IN0 + 4'(w), st[127 - 32*w -: 32]);
            wb_write(REG_KEY0 + 4'(w), key[127 - 32*w -: 32]);
        end
    endtask

    task automatic start_round(input round_kind_e kind);
        wb_write(REG_CTRL, {30'd0, kind == ROUND_FINAL, 1'b1});
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int polls;
        status = 32'd0;
        polls  = 0;
        while (!status[1]) begin
            if (polls == POLL_LIMIT) begin
                $display("engine did not report done after %0d STATUS polls", POLL_LIMIT);
                abort_run();
            end
            wb_read(REG_STATUS, status);
            polls++;
        end
        check_word("STATUS at done", status, 32'h2);
    endtask

    task automatic read_result(output aes_state_t got);
        logic [31:0] word;
        for (int w = 0; w < 4; w++) begin
            wb_read(REG_RESULT0 + 4'(w), word);
            got[127 - 32*w -: 32] = word;
        end
    endtask

    task automatic run_round(input aes_state_t st, input aes_state_t key,
                             input round_kind_e kind, input string name);
        aes_state_t got;
        load_inputs(st, key);
        start_round(kind);
        wait_done();
        read_result(got);
        check_state(name, got, inv_round(st, key, kind));
    endtask

    // an ack is only legal inside an open bus cycle
    always @(negedge clk) begin
        if (rst_n && wb_ack && !(wb_cyc && wb_stb)) begin
            $display("ack seen at %0t without an open bus cycle", $time);
            abort_run();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        logic [31:0] word;
        logic [31:0] new_word;
        aes_state_t  st;
        aes_state_t  key;
        aes_state_t  got;
        round_kind_e kind;

        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 4'd0;
        wb_dat_w = 32'd0;
        void'($urandom(32'hdc98_6de3));
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle bus for a while, the monitor flags any stray ack
        repeat (8) @(posedge clk);
        #1;
        wb_read(REG_STATUS, word);
        check_word("STATUS after reset", word, 32'd0);
        for (int w = 0; w < 4; w++) begin
            wb_read(REG_RESULT0 + 4'(w), word);
            check_word($sformatf("RESULT%0d after reset", w), word, 32'd0);
        end

        for (int w = 0; w < 4; w++) begin
            wb_write(REG_STATE_IN0 + 4'(w), 32'h3c5a_0000 | 32'(w));
            wb_write(REG_KEY0 + 4'(w), 32'hc3a5_0000 | 32'(w + 4));
        end
        for (int w = 0; w < 4; w++) begin
            wb_read(REG_STATE_IN0 + 4'(w), word);
            check_word($sformatf("STATE_IN%0d", w), word, 32'h3c5a_0000 | 32'(w));
            wb_read(REG_KEY0 + 4'(w), word);
            check_word($sformatf("KEY%0d", w), word, 32'hc3a5_0000 | 32'(w + 4));
        end
        wb_write(REG_CTRL, 32'h2);
        wb_read(REG_CTRL, word);
        check_word("CTRL final bit set", word, 32'h2);
        wb_write(REG_CTRL, 32'h0);
        wb_read(REG_CTRL, word);
        check_word("CTRL final bit clear", word, 32'h0);

        // sixteen states holding bytes 0x00 to 0xff between them
        for (int i = 0; i < 16; i++) begin
            for (int k = 0; k < 16; k++) begin
                st[127 - 8*k -: 8] = 8'(16*i + k);
            end
            run_round(st, '0, ROUND_FINAL, "S-box sweep result");
        end

        for (int i = 0; i < 200; i++) begin
            st   = {$urandom, $urandom, $urandom, $urandom};
            key  = {$urandom, $urandom, $urandom, $urandom};
            kind = ($urandom_range(1, 0) == 1) ? ROUND_FINAL : ROUND_MIDDLE;
            run_round(st, key, kind, "random round result");
        end

        // the registered ack allows one access in the three busy cycles
        st       = {$urandom, $urandom, $urandom, $urandom};
        key      = {$urandom, $urandom, $urandom, $urandom};
        new_word = $urandom;
        load_inputs(st, key);
        start_round(ROUND_MIDDLE);
        wb_write(REG_STATE_IN0, new_word);
        wait_done();
        read_result(got);
        check_state("snapshot round result", got, inv_round(st, key, ROUND_MIDDLE));
        wb_read(REG_CTRL, word);
        check_word("CTRL start bit after a start", word, 32'h0);

        st[127:96] = new_word;
        start_round(ROUND_MIDDLE);
        start_round(ROUND_FINAL);
        wait_done();
        read_result(got);
        check_state("round after ignored start", got, inv_round(st, key, ROUND_MIDDLE));

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
verilog/aes_inv_pkg.sv
verilog/aes_sbox_n.sv
verilog/aes_inv_sub_shift.sv
verilog/aes_inv_key_mix.sv
verilog/aes_inv_round_regs.sv
verilog/aes_inv_round_top.sv
tests/aes_inv_round_tb.sv

// File: Makefile
# Verilator build and run of the AES-128 inverse round engine testbench

TOP := aes_inv_round_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

run: build
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" sim.log || (echo "simulation ended without a verdict"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module aes_inv_round_top -f files.f

clean:
	rm -rf obj_dir sim.log
